/* i2c_master.f */
+incdir+include
verilog/i2c_frame_pkg.sv
verilog/i2c_control_pkg.sv
verilog/i2c_phase_timer.sv
verilog/i2c_byte_shifter.sv
verilog/i2c_sequencer.sv
verilog/i2c_master.sv
sim/i2c_target_model.sv
sim/i2c_master_tb.sv

/* include/i2c_master_params.svh */
`ifndef I2C_MASTER_PARAMS_SVH
`define I2C_MASTER_PARAMS_SVH

// target address, without the direction bit
`define I2C_ADDRESS_WIDTH 7
`define I2C_BYTE_WIDTH 8

// divider input of the phase timer
`define I2C_DIVIDER_WIDTH 16
`define I2C_PHASE_COUNT 4

`endif

/* sim/i2c_master_tb.sv */
`timescale 1ns/1ps
`include "i2c_master_params.svh"

module i2c_master_tb;

    import i2c_frame_pkg::*;

    localparam int CLOCK_PERIOD = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int DIVIDER      = 3;
    localparam int ROW_COUNT    = 13;
    // a full read per row, every phase stretched to the worst case, doubled
    localparam int CYCLE_LIMIT  = 2 * ROW_COUNT * 5 * 9 * 4 * (DIVIDER + 1 + 8);

    logic                          clock;
    logic                          reset_n;
    logic                          enable;
    i2c_dir_e                      read_write;
    logic [`I2C_ADDRESS_WIDTH-1:0] device_address;
    logic [`I2C_BYTE_WIDTH-1:0]    register_address;
    logic [`I2C_BYTE_WIDTH-1:0]    write_data;
    logic [`I2C_DIVIDER_WIDTH-1:0] divider;
    logic                          busy;
    logic [`I2C_BYTE_WIDTH-1:0]    read_data;
    logic                          ack_error;
    wire                           scl;
    wire                           sda;
    int                            cycle_count = 0;
    int                            row_total   = 0;

    ////////////////////
    // transaction table

    i2c_dir_e                      row_dir       [ROW_COUNT];
    logic [`I2C_ADDRESS_WIDTH-1:0] row_device    [ROW_COUNT];
    logic [`I2C_BYTE_WIDTH-1:0]    row_register  [ROW_COUNT];
    logic [`I2C_BYTE_WIDTH-1:0]    row_data      [ROW_COUNT];
    logic                          row_extra     [ROW_COUNT];
    logic                          row_ack_error [ROW_COUNT];
    logic [`I2C_BYTE_WIDTH-1:0]    row_read_data [ROW_COUNT];

    pullup (scl);
    pullup (sda);

    i2c_master i_dut (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .write_data       (write_data),
        .divider          (divider),
        .busy             (busy),
        .read_data        (read_data),
        .ack_error        (ack_error),
        .scl              (scl),
        .sda              (sda)
    );

    i2c_target_model i_target (
        .clock (clock),
        .scl   (scl),
        .sda   (sda)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: no end of the run after %0d clock cycles", cycle_count);
            $display("TESTS FAILED");
            $fatal(1, "run stopped at the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic add_row(input i2c_dir_e dir, input logic [6:0] device,
                           input logic [7:0] register_index, input logic [7:0] data,
                           input logic extra, input logic error, input logic [7:0] expected);
        row_dir[row_total]       = dir;
        row_device[row_total]    = device;
        row_register[row_total]  = register_index;
        row_data[row_total]      = data;
        row_extra[row_total]     = extra;
        row_ack_error[row_total] = error;
        row_read_data[row_total] = expected;
        row_total                = row_total + 1;
    endtask

    task automatic fill_table();
        // untouched registers hold index ^ A5
        add_row(dir_read,  7'h50, 8'h10, 8'h00, 1'b0, 1'b0, 8'h10 ^ 8'hA5);
        add_row(dir_write, 7'h50, 8'h22, 8'h3C, 1'b0, 1'b0, 8'h00);
        add_row(dir_read,  7'h50, 8'h22, 8'h00, 1'b0, 1'b0, 8'h3C);
        add_row(dir_write, 7'h50, 8'h23, 8'hC7, 1'b0, 1'b0, 8'h00);
        add_row(dir_read,  7'h50, 8'h22, 8'h00, 1'b0, 1'b0, 8'h3C);
        add_row(dir_read,  7'h50, 8'h23, 8'h00, 1'b0, 1'b0, 8'hC7);
        // wrong address, nothing may be written
        add_row(dir_write, 7'h51, 8'h40, 8'h99, 1'b0, 1'b1, 8'h00);
        add_row(dir_read,  7'h50, 8'h40, 8'h00, 1'b0, 1'b0, 8'h40 ^ 8'hA5);
        // failed read keeps the last good value
        add_row(dir_read,  7'h51, 8'h22, 8'h00, 1'b0, 1'b1, 8'h40 ^ 8'hA5);
        add_row(dir_write, 7'h50, 8'h41, 8'h6E, 1'b0, 1'b0, 8'h00);
        add_row(dir_read,  7'h50, 8'h41, 8'h00, 1'b0, 1'b0, 8'h6E);
        add_row(dir_read,  7'h50, 8'h55, 8'h00, 1'b1, 1'b0, 8'h55 ^ 8'hA5);
        add_row(dir_read,  7'h50, 8'h10, 8'h00, 1'b0, 1'b0, 8'h10 ^ 8'hA5);
    endtask

    task automatic run_row(input int index);
        while (busy !== 1'b0) next_cycle();
        read_write       = row_dir[index];
        device_address   = row_device[index];
        register_address = row_register[index];
        write_data       = row_data[index];
        enable           = 1'b1;
        next_cycle();
        enable = 1'b0;
        check_value("busy", busy, 1'b1);
        if (row_extra[index]) begin
            // a write to register 10 that must be ignored
            repeat (20) next_cycle();
            read_write       = dir_write;
            register_address = 8'h10;
            write_data       = 8'h5A;
            enable           = 1'b1;
            next_cycle();
            enable = 1'b0;
        end
        while (busy !== 1'b0) next_cycle();
        check_value("ack_error", ack_error, row_ack_error[index]);
        if (row_dir[index] == dir_read) begin
            check_value("read_data", read_data, row_read_data[index]);
        end
        repeat (3) next_cycle();
        check_value("busy", busy, 1'b0);
    endtask

    initial begin
        reset_n          = 1'b0;
        enable           = 1'b0;
        read_write       = dir_write;
        device_address   = '0;
        register_address = '0;
        write_data       = '0;
        divider          = DIVIDER;
        fill_table();
        repeat (3) @(posedge clock);
        #DRIVE_DELAY;
        reset_n = 1'b1;
        next_cycle();
        check_value("busy", busy, 1'b0);
        check_value("ack_error", ack_error, 1'b0);
        check_value("read_data", read_data, 8'h00);
        check_value("scl", scl, 1'b1);
        check_value("sda", sda, 1'b1);
        for (int i = 0; i < row_total; i++) begin
            run_row(i);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* sim/i2c_target_model.sv */
`timescale 1ns/1ps
`include "i2c_master_params.svh"

module i2c_target_model #(
    parameter logic [`I2C_ADDRESS_WIDTH-1:0] DEVICE_ADDRESS     = 7'h50,
    parameter int                            NOMINAL_LOW_CLOCKS = 8
) (
    input logic clock,
    inout wire  scl,
    inout wire  sda
);

    import i2c_frame_pkg::*;

    localparam int MODE_IDLE     = 0;
    localparam int MODE_RECEIVE  = 1;
    localparam int MODE_ACK      = 2;
    localparam int MODE_SEND     = 3;
    localparam int MODE_HOST_ACK = 4;

    logic [`I2C_BYTE_WIDTH-1:0] registers [0:255];
    logic [`I2C_BYTE_WIDTH-1:0] shift_in    = '0;
    logic [`I2C_BYTE_WIDTH-1:0] tx_byte     = '0;
    logic [`I2C_BYTE_WIDTH-1:0] reg_pointer = '0;
    i2c_byte_u                  first_byte;
    int                         mode        = MODE_IDLE;
    int                         bit_count   = 0;
    int                         byte_count  = 0;
    logic                       reading     = 1'b0;
    logic                       host_nack   = 1'b0;
    logic                       scl_hold    = 1'b0;
    logic                       sda_hold    = 1'b0;
    integer                     seed        = 17;
    int                         stretch     = 0;

    assign scl = scl_hold ? 1'b0 : 1'bz;
    assign sda = sda_hold ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 256; i++) begin
            registers[i] = i[7:0] ^ 8'hA5;
        end
    end

    ////////////////////
    // start, repeated start and stop

    always @(negedge sda) begin
        if (scl === 1'b1 && sda === 1'b0) begin
            mode       = MODE_RECEIVE;
            bit_count  = 0;
            byte_count = 0;
            sda_hold   = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1 && sda === 1'b1) begin
            mode     = MODE_IDLE;
            sda_hold = 1'b0;
        end
    end

    ////////////////////
    // bit level

    always @(posedge scl) begin
        if (scl === 1'b1) begin
            case (mode)
                MODE_RECEIVE: begin
                    shift_in  = {shift_in[`I2C_BYTE_WIDTH-2:0], sda};
                    bit_count = bit_count + 1;
                end
                MODE_SEND: begin
                    bit_count = bit_count + 1;
                end
                MODE_HOST_ACK: begin
                    host_nack = (sda !== 1'b0);
                end
                default: begin
                end
            endcase
        end
    end

    // SDA only changes while SCL is low
    always @(negedge scl) begin
        if (scl === 1'b0) begin
            case (mode)
                MODE_RECEIVE: begin
                    if (bit_count == 8 && byte_count == 0) begin
                        first_byte.raw = shift_in;
                        if (first_byte.address.device_address == DEVICE_ADDRESS) begin
                            reading  = (first_byte.address.direction == dir_read);
                            mode     = MODE_ACK;
                            sda_hold = 1'b1;
                        end
                        else begin
                            mode = MODE_IDLE;
                        end
                    end
                    else if (bit_count == 8) begin
                        if (byte_count == 1) begin
                            reg_pointer = shift_in;
                        end
                        else begin
                            registers[reg_pointer] = shift_in;
                            reg_pointer            = reg_pointer + 1'b1;
                        end
                        mode     = MODE_ACK;
                        sda_hold = 1'b1;
                    end
                    if (bit_count == 8) begin
                        byte_count = byte_count + 1;
                    end
                end
                MODE_ACK: begin
                    bit_count = 0;
                    sda_hold  = 1'b0;
                    mode      = MODE_RECEIVE;
                    if (reading) begin
                        tx_byte  = registers[reg_pointer];
                        mode     = MODE_SEND;
                        sda_hold = !tx_byte[7];
                    end
                end
                MODE_SEND: begin
                    if (bit_count < 8) begin
                        sda_hold = !tx_byte[7 - bit_count];
                    end
                    else begin
                        sda_hold = 1'b0;
                        mode     = MODE_HOST_ACK;
                    end
                end
                MODE_HOST_ACK: begin
                    mode = MODE_IDLE;
                    if (!host_nack) begin
                        reg_pointer = reg_pointer + 1'b1;
                        tx_byte     = registers[reg_pointer];
                        bit_count   = 0;
                        mode        = MODE_SEND;
                        sda_hold    = !tx_byte[7];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    ////////////////////
    // clock stretching

    // extra 0..7 clocks past the nominal low time of the bus
    always @(negedge scl) begin
        if (scl === 1'b0) begin
            stretch  = $random(seed) & 32'd7;
            scl_hold = 1'b1;
            repeat (NOMINAL_LOW_CLOCKS + stretch) @(negedge clock);
            scl_hold = 1'b0;
        end
    end

endmodule

/* verilog/i2c_byte_shifter.sv */
`timescale 1ns/1ps
`include "i2c_master_params.svh"

module i2c_byte_shifter (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       load,
    input  i2c_frame_pkg::i2c_byte_u   load_byte,
    input  logic                       shift,
    input  logic                       sda_in,
    output logic                       tx_bit,
    output logic [`I2C_BYTE_WIDTH-1:0] rx_byte,
    output logic                       byte_done
);

    localparam int COUNT_WIDTH = $clog2(`I2C_BYTE_WIDTH + 1);

    logic [`I2C_BYTE_WIDTH-1:0] shift_reg;
    logic [COUNT_WIDTH-1:0]     bits_left;

    ////////////////////
    // data path

    // msb goes out first, bus bits come in at the bottom
    always_ff @(posedge clock) begin
        if (load) begin
            shift_reg <= load_byte.raw;
        end
        else if (shift) begin
            shift_reg <= {shift_reg[`I2C_BYTE_WIDTH-2:0], sda_in};
        end
    end

    ////////////////////
    // bit counter

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            bits_left <= '0;
        end
        else if (load) begin
            bits_left <= COUNT_WIDTH'(`I2C_BYTE_WIDTH);
        end
        else if (shift && bits_left != '0) begin
            bits_left <= bits_left - 1'b1;
        end
    end

    assign tx_bit    = shift_reg[`I2C_BYTE_WIDTH-1];
    // a read loads all ones, so after eight shifts only bus bits remain
    assign rx_byte   = shift_reg;
    assign byte_done = (bits_left == '0);

endmodule

/* verilog/i2c_control_pkg.sv */
`include "i2c_master_params.svh"

package i2c_control_pkg;

    // quarters of one SCL bit
    typedef enum logic [$clog2(`I2C_PHASE_COUNT)-1:0] {
        phase_low_set  = 2'd0,
        phase_rise     = 2'd1,
        phase_high     = 2'd2,
        phase_low_hold = 2'd3
    } i2c_phase_e;

    ////////////////////
    // transaction FSM, one bit per state step
    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_start     = 3'd1,
        st_send_byte = 3'd2,
        st_check_ack = 3'd3,
        st_restart   = 3'd4,
        st_read_byte = 3'd5,
        st_send_nack = 3'd6,
        st_stop      = 3'd7
    } i2c_state_e;

endpackage

/* verilog/i2c_frame_pkg.sv */
`include "i2c_master_params.svh"

package i2c_frame_pkg;

    // direction bit, last bit of the address byte
    typedef enum logic {
        dir_write = 1'b0,
        dir_read  = 1'b1
    } i2c_dir_e;

    // first byte after a start
    typedef struct packed {
        logic [`I2C_ADDRESS_WIDTH-1:0] device_address;
        i2c_dir_e                      direction;
    } i2c_address_byte_s;

    ////////////////////
    // one byte on the bus, plain or as an address byte
    typedef union packed {
        logic [`I2C_BYTE_WIDTH-1:0] raw;
        i2c_address_byte_s          address;
    } i2c_byte_u;

endpackage

/* verilog/i2c_master.sv */
`timescale 1ns/1ps
`include "i2c_master_params.svh"

module i2c_master (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          enable,
    input  i2c_frame_pkg::i2c_dir_e       read_write,
    input  logic [`I2C_ADDRESS_WIDTH-1:0] device_address,
    input  logic [`I2C_BYTE_WIDTH-1:0]    register_address,
    input  logic [`I2C_BYTE_WIDTH-1:0]    write_data,
    input  logic [`I2C_DIVIDER_WIDTH-1:0] divider,
    output logic                          busy,
    output logic [`I2C_BYTE_WIDTH-1:0]    read_data,
    output logic                          ack_error,
    inout  wire                           scl,
    inout  wire                           sda
);

    import i2c_frame_pkg::*;
    import i2c_control_pkg::*;

    logic                       run;
    i2c_phase_e                 phase;
    logic                       phase_step;
    logic                       load;
    i2c_byte_u                  load_byte;
    logic                       shift;
    logic                       tx_bit;
    logic [`I2C_BYTE_WIDTH-1:0] rx_byte;
    logic                       byte_done;
    logic                       scl_low;
    logic                       sda_low;
    logic                       scl_in;
    logic                       sda_in;

    ////////////////////
    // open drain pins, pulled high outside

    assign scl    = scl_low ? 1'b0 : 1'bz;
    assign sda    = sda_low ? 1'b0 : 1'bz;
    assign scl_in = scl;
    assign sda_in = sda;

    i2c_phase_timer i_phase_timer (
        .clock      (clock),
        .reset_n    (reset_n),
        .run        (run),
        .divider    (divider),
        .scl_in     (scl_in),
        .phase      (phase),
        .phase_step (phase_step)
    );

    i2c_byte_shifter i_byte_shifter (
        .clock     (clock),
        .reset_n   (reset_n),
        .load      (load),
        .load_byte (load_byte),
        .shift     (shift),
        .sda_in    (sda_in),
        .tx_bit    (tx_bit),
        .rx_byte   (rx_byte),
        .byte_done (byte_done)
    );

    i2c_sequencer i_sequencer (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .write_data       (write_data),
        .phase            (phase),
        .phase_step       (phase_step),
        .tx_bit           (tx_bit),
        .rx_byte          (rx_byte),
        .byte_done        (byte_done),
        .sda_in           (sda_in),
        .run              (run),
        .load             (load),
        .load_byte        (load_byte),
        .shift            (shift),
        .scl_low          (scl_low),
        .sda_low          (sda_low),
        .busy             (busy),
        .read_data        (read_data),
        .ack_error        (ack_error)
    );

endmodule

/* verilog/i2c_phase_timer.sv */
`timescale 1ns/1ps
`include "i2c_master_params.svh"

module i2c_phase_timer (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          run,
    input  logic [`I2C_DIVIDER_WIDTH-1:0] divider,
    input  logic                          scl_in,
    output i2c_control_pkg::i2c_phase_e   phase,
    output logic                          phase_step
);

    import i2c_control_pkg::*;

    logic [`I2C_DIVIDER_WIDTH-1:0] count;
    logic                          count_done;
    logic                          scl_seen;
    logic                          scl_wait;

    ////////////////////
    // phase end detect

    assign count_done = (count == divider);

    // target may hold SCL low after we release it
    assign scl_wait = (phase == phase_rise) && !scl_seen;

    assign phase_step = run && count_done && !scl_wait;

    ////////////////////
    // counters

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            scl_seen <= 1'b1;
        end
        else begin
            // one flop on the pin
            scl_seen <= scl_in;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            phase <= phase_low_set;
            count <= '0;
        end
        else if (!run) begin
            phase <= phase_low_set;
            count <= '0;
        end
        else if (phase_step) begin
            // wraps from low_hold back to low_set
            phase <= i2c_phase_e'(phase + 2'd1);
            count <= '0;
        end
        else if (!count_done) begin
            count <= count + 1'b1;
        end
        // count parks at divider while SCL is stretched
    end

endmodule

/* verilog/i2c_sequencer.sv */
`timescale 1ns/1ps
`include "i2c_master_params.svh"

module i2c_sequencer (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         enable,
    input  i2c_frame_pkg::i2c_dir_e      read_write,
    input  logic [`I2C_ADDRESS_WIDTH-1:0] device_address,
    input  logic [`I2C_BYTE_WIDTH-1:0]   register_address,
    input  logic [`I2C_BYTE_WIDTH-1:0]   write_data,
    input  i2c_control_pkg::i2c_phase_e  phase,
    input  logic                         phase_step,
    input  logic                         tx_bit,
    input  logic [`I2C_BYTE_WIDTH-1:0]   rx_byte,
    input  logic                         byte_done,
    input  logic                         sda_in,
    output logic                         run,
    output logic                         load,
    output i2c_frame_pkg::i2c_byte_u     load_byte,
    output logic                         shift,
    output logic                         scl_low,
    output logic                         sda_low,
    output logic                         busy,
    output logic [`I2C_BYTE_WIDTH-1:0]   read_data,
    output logic                         ack_error
);

    import i2c_frame_pkg::*;
    import i2c_control_pkg::*;

    i2c_state_e                    state;
    i2c_state_e                    state_next;
    logic [`I2C_ADDRESS_WIDTH-1:0] saved_device;
    logic [`I2C_BYTE_WIDTH-1:0]    saved_register;
    logic [`I2C_BYTE_WIDTH-1:0]    saved_data;
    i2c_dir_e                      saved_dir;
    logic [1:0]                    byte_index;
    logic                          nack_seen;
    logic                          accept;
    logic                          bit_end;
    logic                          sample;
    logic                          clock_low;
    logic                          scl_next;
    logic                          sda_next;

    assign accept    = (state == st_idle) && enable;
    assign bit_end   = phase_step && (phase == phase_low_hold);
    assign sample    = phase_step && (phase == phase_high);
    assign clock_low = (phase == phase_low_set) || (phase == phase_low_hold);

    assign busy  = (state != st_idle);
    assign run   = (state != st_idle);
    assign shift = sample && (state == st_send_byte || state == st_read_byte);

    ////////////////////
    // request capture

    always_ff @(posedge clock) begin
        if (accept) begin
            saved_device   <= device_address;
            saved_register <= register_address;
            saved_data     <= write_data;
            saved_dir      <= read_write;
        end
    end

    ////////////////////
    // next state and byte loads

    always_comb begin
        state_next    = state;
        load          = 1'b0;
        load_byte.raw = '1;
        case (state)
            st_idle: begin
                if (enable) begin
                    state_next = st_start;
                end
            end
            st_start: begin
                if (bit_end) begin
                    state_next                       = st_send_byte;
                    load                             = 1'b1;
                    load_byte.address.device_address = saved_device;
                    load_byte.address.direction      = dir_write;
                end
            end
            st_send_byte: begin
                if (bit_end && byte_done) begin
                    state_next = st_check_ack;
                end
            end
            st_check_ack: begin
                if (bit_end) begin
                    if (nack_seen) begin
                        state_next = st_stop;
                    end
                    else if (byte_index == 2'd0) begin
                        state_next    = st_send_byte;
                        load          = 1'b1;
                        load_byte.raw = saved_register;
                    end
                    else if (byte_index == 2'd1 && saved_dir == dir_write) begin
                        state_next    = st_send_byte;
                        load          = 1'b1;
                        load_byte.raw = saved_data;
                    end
                    else if (byte_index == 2'd1) begin
                        state_next = st_restart;
                    end
                    else if (saved_dir == dir_write) begin
                        state_next = st_stop;
                    end
                    else begin
                        // all ones keeps SDA released while the target drives
                        state_next = st_read_byte;
                        load       = 1'b1;
                    end
                end
            end
            st_restart: begin
                if (bit_end) begin
                    state_next                       = st_send_byte;
                    load                             = 1'b1;
                    load_byte.address.device_address = saved_device;
                    load_byte.address.direction      = dir_read;
                end
            end
            st_read_byte: begin
                if (bit_end && byte_done) begin
                    state_next = st_send_nack;
                end
            end
            st_send_nack: begin
                if (bit_end) begin
                    state_next = st_stop;
                end
            end
            st_stop: begin
                if (bit_end) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    ////////////////////
    // line levels per state and phase

    always_comb begin
        scl_next = clock_low;
        sda_next = 1'b0;
        case (state)
            st_idle: begin
                scl_next = 1'b0;
            end
            st_start: begin
                // SDA falls while SCL is still high
                scl_next = (phase == phase_low_hold);
                sda_next = (phase == phase_high) || (phase == phase_low_hold);
            end
            st_restart: begin
                sda_next = (phase == phase_high) || (phase == phase_low_hold);
            end
            st_send_byte: begin
                // tx_bit moves on at the end of high, so hold through low_hold
                sda_next = (phase == phase_low_hold) ? sda_low : !tx_bit;
            end
            st_stop: begin
                // SDA rises while SCL is high
                scl_next = (phase == phase_low_set);
                sda_next = (phase == phase_low_set) || (phase == phase_rise);
            end
            default: begin
                // ack, read and nack bits leave SDA released
                sda_next = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= st_idle;
            byte_index <= '0;
            nack_seen  <= 1'b0;
            ack_error  <= 1'b0;
            read_data  <= '0;
            scl_low    <= 1'b0;
            sda_low    <= 1'b0;
        end
        else begin
            state   <= state_next;
            scl_low <= scl_next;
            sda_low <= sda_next;
            if (accept) begin
                byte_index <= '0;
                ack_error  <= 1'b0;
            end
            if (sample && state == st_check_ack) begin
                nack_seen <= sda_in;
            end
            if (bit_end && state == st_check_ack) begin
                if (nack_seen) begin
                    ack_error <= 1'b1;
                end
                else begin
                    byte_index <= byte_index + 1'b1;
                end
            end
            if (bit_end && state == st_read_byte && byte_done) begin
                read_data <= rx_byte;
            end
        end
    end

endmodule
